/* build.f */
+incdir+verilog
verilog/fcvt_pkg.sv
verilog/fcvt_stage_ctrl.sv
verilog/fcvt_unpack.sv
verilog/fcvt_align.sv
verilog/fcvt_round.sv
verilog/fcvt_top.sv
dv/fcvt_tb.sv

/* dv/fcvt_stim.txt */
// op mod src dst rnd operand result status, all hex, one conversion per line
// op 0 F2F 1 F2I 2 I2F; fmt 0 binary32 1 binary16; rnd 0 RNE 1 RTZ 2 RDN 3 RUP 4 RMM
0 0 0 1 0 3F800000 FFFF3C00 00
0 0 0 1 0 477FE000 FFFF7BFF 00
0 0 0 1 0 47800000 FFFF7C00 05
0 0 0 1 1 47800000 FFFF7BFF 05
0 0 0 1 3 C7800000 FFFFFBFF 05
0 0 0 1 0 477FF000 FFFF7C00 05
0 0 0 1 0 3F801000 FFFF3C00 01
0 0 0 1 0 33800000 FFFF0001 00
0 0 0 1 0 33000000 FFFF0000 03
0 0 0 1 2 80800000 FFFF8001 03
0 0 1 0 0 FFFF3C00 3F800000 00
0 0 1 0 0 FFFF03FF 387FC000 00
0 0 1 0 0 FFFFFC00 FF800000 00
0 0 1 0 0 FFFF7E00 7FC00000 00
0 0 1 0 0 FFFF7C01 7FC00000 10
0 0 0 1 0 7F800001 FFFF7E00 10
0 0 0 1 0 80000000 FFFF8000 00
1 0 0 0 0 40200000 00000002 01
1 0 0 0 3 40200000 00000003 01
1 0 0 0 2 C0200000 FFFFFFFD 01
1 0 0 0 4 C0200000 FFFFFFFD 01
1 0 0 0 1 C0200000 FFFFFFFE 01
1 1 0 0 1 BF800000 00000000 10
1 1 0 0 1 BF000000 00000000 01
1 0 0 0 0 4F000000 7FFFFFFF 10
1 0 0 0 0 CF000000 80000000 00
1 0 0 0 0 7FC00000 7FFFFFFF 10
1 1 0 0 0 FF800000 00000000 10
1 0 1 0 0 FFFF5640 00000064 00
2 0 0 0 0 00000000 00000000 00
2 0 0 0 0 FFFFFFFF BF800000 00
2 1 0 0 0 FFFFFFFF 4F800000 01
2 1 0 0 1 FFFFFFFF 4F7FFFFF 01
2 0 0 0 0 01000001 4B800000 01
2 0 0 0 2 FEFFFFFF CB800001 01
2 0 0 1 0 00011170 FFFF7C00 05

/* dv/fcvt_tb.sv */
// ----------------------------------------------------------
// Testbench for the conversion unit. Reads conversions and
// expected results from the stimulus file, runs them once at
// full rate and once under random output back-pressure
// ----------------------------------------------------------
`timescale 1ns/1ps
`include "fcvt_cfg.svh"

module fcvt_tb;

  localparam int    MAX_VEC   = 64;
  localparam string STIM_FILE = "dv/fcvt_stim.txt";

  logic               clk_i = 1'b0;
  logic               rst_n_i, in_valid_i, out_ready_i;
  logic               op_mod_i, src_fmt_i, dst_fmt_i;
  fcvt_pkg::operand_u operand_i, result_o;
  logic [1:0]         op_i;
  logic [2:0]         rnd_mode_i;
  logic               in_ready_o, out_valid_o, busy_o;
  logic [4:0]         status_o;

  // Vectors from the stimulus file
  logic [1:0]             vec_op [MAX_VEC];
  logic                   vec_mod [MAX_VEC], vec_src [MAX_VEC], vec_dst [MAX_VEC];
  logic [2:0]             vec_rnd [MAX_VEC];
  logic [`FCVT_WIDTH-1:0] vec_operand [MAX_VEC], vec_result [MAX_VEC];
  logic [4:0]             vec_status [MAX_VEC];
  int                     n_vec = 0;
  bit                     loaded = 1'b0;

  fcvt_pkg::operand_u exp_result_q[$];  // Expected values in acceptance order
  logic [4:0]         exp_status_q[$];
  int                 accept_q[$];      // Cycle of acceptance

  int                 cycle = 0;
  int                 n_checked = 0;
  bit                 latency_on = 1'b0;
  bit                 hold_pending = 1'b0;
  fcvt_pkg::operand_u held_result;
  logic [4:0]         held_status;
  logic [31:0]        lcg_state = 32'hc5a1;

  fcvt_top fcvt_top_i (
    .clk_i      (clk_i),      .rst_n_i    (rst_n_i),    .in_valid_i  (in_valid_i),
    .out_ready_i(out_ready_i), .op_mod_i  (op_mod_i),   .src_fmt_i   (src_fmt_i),
    .dst_fmt_i  (dst_fmt_i),  .operand_i  (operand_i),  .op_i        (op_i),
    .rnd_mode_i (rnd_mode_i), .in_ready_o (in_ready_o), .out_valid_o (out_valid_o),
    .busy_o     (busy_o),     .result_o   (result_o),   .status_o    (status_o)
  );

  always #50 clk_i = ~clk_i;  // 100 ns period

  always @(posedge clk_i) cycle <= cycle + 1;

  task automatic abort_run();
    $display("=== FAIL ===");
    $fatal(1, "Run stopped at the first error");
  endtask

  // ----------------------------------------------------------
  // Compare tasks
  // ----------------------------------------------------------
  task automatic check_result(input fcvt_pkg::operand_u got, input fcvt_pkg::operand_u exp);
    if (got !== exp) begin
      $display("error at %0t ns: result_o = %h, expected %h", $time, got.raw, exp.raw);
      abort_run();
    end
  endtask

  task automatic check_status(input logic [4:0] got, input logic [4:0] exp);
    if (got !== exp) begin
      $display("error at %0t ns: status_o = %h, expected %h", $time, got, exp);
      abort_run();
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string name);
    if (got !== exp) begin
      $display("error at %0t ns: %s = %b, expected %b", $time, name, got, exp);
      abort_run();
    end
  endtask

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  task automatic load_vectors();
    int          fd;
    int          cnt;
    string       line;
    logic [31:0] f_op, f_mod, f_src, f_dst, f_rnd, f_opnd, f_res, f_st;
    fd = $fopen(STIM_FILE, "r");
    if (fd == 0) begin
      $display("Could not open the stimulus file %s", STIM_FILE);
      abort_run();
    end
    while (!$feof(fd)) begin
      line = "";
      cnt  = $fgets(line, fd);
      cnt  = $sscanf(line, "%h %h %h %h %h %h %h %h",
                     f_op, f_mod, f_src, f_dst, f_rnd, f_opnd, f_res, f_st);
      if (cnt == 8 && n_vec < MAX_VEC) begin  // Comment lines fail the scan
        vec_op[n_vec]      = f_op[1:0];
        vec_mod[n_vec]     = f_mod[0];
        vec_src[n_vec]     = f_src[0];
        vec_dst[n_vec]     = f_dst[0];
        vec_rnd[n_vec]     = f_rnd[2:0];
        vec_operand[n_vec] = f_opnd;
        vec_result[n_vec]  = f_res;
        vec_status[n_vec]  = f_st[4:0];
        n_vec++;
      end
    end
    $fclose(fd);
    if (n_vec == 0) begin
      $display("The stimulus file holds no conversions");
      abort_run();
    end
  endtask

  task automatic drive_vector(input int idx);
    op_i            <= vec_op[idx];
    op_mod_i        <= vec_mod[idx];
    src_fmt_i       <= vec_src[idx];
    dst_fmt_i       <= vec_dst[idx];
    rnd_mode_i      <= vec_rnd[idx];
    operand_i.raw   <= vec_operand[idx];
    in_valid_i      <= 1'b1;
  endtask

  // One pass over all vectors with optional random back-pressure
  task automatic run_pass(input bit stall);
    int          idx;
    int          done;
    logic [31:0] r;
    idx        = 0;
    done       = 0;
    latency_on <= ~stall;  // Fixed latency only at full rate
    while (done < n_vec) begin
      @(posedge clk_i);
      if (in_valid_i && in_ready_o) begin  // Accepted on this edge
        exp_result_q.push_back(vec_result[idx]);
        exp_status_q.push_back(vec_status[idx]);
        accept_q.push_back(cycle);
        idx++;
      end
      if (out_valid_o && out_ready_i) done++;  // Result taken on this edge
      if (idx < n_vec) drive_vector(idx);
      else             in_valid_i <= 1'b0;
      r = next_rand();
      out_ready_i <= stall ? (r[20] & r[27]) : 1'b1;  // Ready a quarter of the time
    end
  endtask

  // ----------------------------------------------------------
  // Output monitor
  // ----------------------------------------------------------
  always @(posedge clk_i) begin
    int lat;
    if (rst_n_i) begin
      if (hold_pending) begin  // Output held after a stalled edge
        check_flag(out_valid_o, 1'b1, "out_valid_o");
        check_result(result_o, held_result);
        check_status(status_o, held_status);
      end
      if (out_valid_o) check_flag(busy_o, 1'b1, "busy_o");  // Busy while a result waits
      if (out_valid_o && out_ready_i) begin
        if (exp_result_q.size() == 0) begin
          $display("Output transfer at %0t ns with no conversion outstanding", $time);
          abort_run();
        end
        check_result(result_o, exp_result_q.pop_front());
        check_status(status_o, exp_status_q.pop_front());
        lat = cycle - accept_q.pop_front();
        if (latency_on && lat != 2) begin
          $display("Result at %0t ns came %0d cycles after acceptance instead of 2",
                   $time, lat);
          abort_run();
        end
        n_checked++;
      end
      hold_pending = out_valid_o & ~out_ready_i;
      held_result  = result_o;
      held_status  = status_o;
    end
  end

  // Watchdog allows two passes of at most 20 cycles per conversion
  initial begin
    int limit;
    wait (loaded);
    limit = 2 * n_vec * 20 + 50;
    repeat (limit) @(posedge clk_i);
    $display("Timeout: outputs stopped arriving, %0d of %0d results seen", n_checked,
             2 * n_vec);
    abort_run();
  end

  // ----------------------------------------------------------
  // Main sequence
  // ----------------------------------------------------------
  initial begin
    rst_n_i       = 1'b0;
    in_valid_i    = 1'b0;
    out_ready_i   = 1'b0;
    op_i          = `FCVT_OP_F2F;
    op_mod_i      = 1'b0;
    src_fmt_i     = `FCVT_FMT_F32;
    dst_fmt_i     = `FCVT_FMT_F32;
    rnd_mode_i    = `FCVT_RNE;
    operand_i.raw = '0;
    load_vectors();
    loaded = 1'b1;
    repeat (4) @(posedge clk_i);
    rst_n_i <= 1'b1;
    @(posedge clk_i);
    check_flag(out_valid_o, 1'b0, "out_valid_o");  // Idle after reset
    check_flag(busy_o, 1'b0, "busy_o");
    check_flag(in_ready_o, 1'b1, "in_ready_o");
    run_pass(1'b0);
    run_pass(1'b1);
    repeat (2) @(posedge clk_i);
    check_flag(busy_o, 1'b0, "busy_o");
    if (exp_result_q.size() == 0 && n_checked == 2 * n_vec) begin
      $display("=== PASS ===");
      $finish;
    end else begin
      $display("Conversions still outstanding at the end of the run");
      abort_run();
    end
  end

endmodule

/* verilog/fcvt_align.sv */
// ----------------------------------------------------------
// Combinational alignment between the stages: rebias, range
// checks, denormalization and round/sticky extraction
// ----------------------------------------------------------
`timescale 1ns/1ps
`include "fcvt_cfg.svh"

module fcvt_align (
  input  logic signed [`FCVT_EXP_W-1:0] exp_i,
  input  logic [`FCVT_MAN_W-1:0]        mant_i,
  input  logic [1:0]                    op_i,
  input  logic                          op_mod_i,
  input  logic                          dst_fmt_i,
  input  logic                          is_inf_i,
  output logic [`FCVT_WIDTH-1:0]        abs_o,
  output logic [1:0]                    rs_bits_o,
  output logic                          of_pre_o,
  output logic                          uf_pre_o
);

  localparam int EW  = `FCVT_EXP_W;
  localparam int MW  = `FCVT_MAN_W;
  localparam int SW  = $clog2(2 * MW);
  localparam int R32 = 2 * MW - 2 - `FCVT_F32_MAN;  // Round bit for binary32
  localparam int R16 = 2 * MW - 2 - `FCVT_F16_MAN;  // Round bit for binary16

  logic                     is_f2i, is_f16;
  logic signed [EW-1:0]     dst_bias, exp_lim, man_w, dest_exp;
  logic [`FCVT_F32_EXP-1:0] exp_fld;
  logic [2*MW-1:0]          pre, shifted;
  logic [SW-1:0]            shamt;

  assign is_f2i   = (op_i == `FCVT_OP_F2I);
  assign is_f16   = (dst_fmt_i == `FCVT_FMT_F16);
  assign dst_bias = is_f16 ? EW'(`FCVT_F16_BIAS) : EW'(`FCVT_F32_BIAS);
  assign exp_lim  = is_f16 ? EW'((1 << `FCVT_F16_EXP) - 1) : EW'((1 << `FCVT_F32_EXP) - 1);
  assign man_w    = is_f16 ? EW'(`FCVT_F16_MAN) : EW'(`FCVT_F32_MAN);
  assign dest_exp = exp_i + dst_bias;

  always_comb begin
    pre      = {mant_i, {MW{1'b0}}};  // Mantissa at the top of the shifter
    shamt    = '0;
    exp_fld  = dest_exp[`FCVT_F32_EXP-1:0];
    of_pre_o = 1'b0;
    uf_pre_o = 1'b0;
    if (is_f2i) begin
      // Too large before rounding
      // Signed exactly 2^31 is caught by the round stage
      if (exp_i >= EW'(MW) || (!op_mod_i && exp_i == EW'(MW - 1) && |mant_i[MW-2:0])) begin
        of_pre_o = 1'b1;
      end else if (exp_i < EW'(-1)) begin
        shamt = SW'(MW + 1);  // All bits into sticky
      end else begin
        shamt = SW'(EW'(MW - 1) - exp_i);  // Binary point to bit MW
      end
    end else begin
      // Overflow or infinity saturates to the largest finite with R and S set
      if (dest_exp >= exp_lim || is_inf_i) begin
        exp_fld  = `FCVT_F32_EXP'(exp_lim - EW'(1));
        pre      = '1;
        of_pre_o = 1'b1;
      end else if (dest_exp < EW'(1)) begin
        exp_fld  = '0;  // Subnormal result
        uf_pre_o = 1'b1;
        // Bounded shift keeps the implicit bit in the sticky range
        shamt    = (dest_exp < -man_w) ? SW'(man_w + EW'(2)) : SW'(EW'(1) - dest_exp);
      end
    end
  end

  assign shifted = pre >> shamt;

  // Pack exponent and mantissa or the integer without the implicit bit
  always_comb begin
    if (is_f2i) begin
      abs_o     = shifted[2*MW-1:MW];
      rs_bits_o = {shifted[MW-1], |shifted[MW-2:0]};
    end else if (is_f16) begin
      abs_o     = {{(`FCVT_WIDTH-`FCVT_F16_EXP-`FCVT_F16_MAN){1'b0}},
                   exp_fld[`FCVT_F16_EXP-1:0], shifted[2*MW-2 -: `FCVT_F16_MAN]};
      rs_bits_o = {shifted[R16], |shifted[R16-1:0]};
    end else begin
      abs_o     = {1'b0, exp_fld, shifted[2*MW-2 -: `FCVT_F32_MAN]};
      rs_bits_o = {shifted[R32], |shifted[R32-1:0]};
    end
  end

endmodule

/* verilog/fcvt_cfg.svh */
// ----------------------------------------------------------
// Widths, format fields and codes for the conversion unit
// Included by every RTL file and the testbench that needs them
// ----------------------------------------------------------
`ifndef FCVT_CFG_SVH
`define FCVT_CFG_SVH

`define FCVT_WIDTH    32  // Operand and result word
`define FCVT_MAN_W    32  // Internal mantissa, max of 24 and int width
`define FCVT_EXP_W    10  // Signed internal exponent
`define FCVT_LZC_W    5   // Leading-zero count

`define FCVT_F32_EXP  8
`define FCVT_F32_MAN  23
`define FCVT_F32_BIAS 127
`define FCVT_F16_EXP  5
`define FCVT_F16_MAN  10
`define FCVT_F16_BIAS 15

// Operations
`define FCVT_OP_F2F   2'd0
`define FCVT_OP_F2I   2'd1
`define FCVT_OP_I2F   2'd2

// Float formats
`define FCVT_FMT_F32  1'b0
`define FCVT_FMT_F16  1'b1

// IEEE rounding modes
`define FCVT_RNE      3'd0
`define FCVT_RTZ      3'd1
`define FCVT_RDN      3'd2
`define FCVT_RUP      3'd3
`define FCVT_RMM      3'd4

// Status bit positions
`define FCVT_NV       4
`define FCVT_DZ       3
`define FCVT_OF       2
`define FCVT_UF       1
`define FCVT_NX       0

`endif

/* verilog/fcvt_pkg.sv */
// ----------------------------------------------------------
// Operand word type shared by the conversion unit
// One 32-bit word seen as binary32, boxed binary16 or integer
// ----------------------------------------------------------
`include "fcvt_cfg.svh"

package fcvt_pkg;

  typedef union packed {
    // binary32 view
    struct packed {
      logic                     sign;
      logic [`FCVT_F32_EXP-1:0] exp;
      logic [`FCVT_F32_MAN-1:0] man;
    } f32;
    // binary16 in the low half, upper half is the NaN-box
    struct packed {
      logic [`FCVT_WIDTH-`FCVT_F16_EXP-`FCVT_F16_MAN-2:0] box;
      logic                                               sign;
      logic [`FCVT_F16_EXP-1:0]                           exp;
      logic [`FCVT_F16_MAN-1:0]                           man;
    } f16;
    logic [`FCVT_WIDTH-1:0] raw;  // Raw integer
  } operand_u;

endpackage

/* verilog/fcvt_round.sv */
// ----------------------------------------------------------
// Second stage: rounding, special results, status selection
// and the output register loaded on en_i
// ----------------------------------------------------------
`timescale 1ns/1ps
`include "fcvt_cfg.svh"

module fcvt_round (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic                   en_i,
  input  logic [`FCVT_WIDTH-1:0] abs_i,
  input  logic [1:0]             rs_bits_i,
  input  logic                   sign_i,
  input  logic                   of_pre_i,
  input  logic                   uf_pre_i,
  input  logic                   is_zero_i,
  input  logic                   is_inf_i,
  input  logic                   is_nan_i,
  input  logic                   is_snan_i,
  input  logic                   mant_zero_i,
  input  logic [1:0]             op_i,
  input  logic                   op_mod_i,
  input  logic                   dst_fmt_i,
  input  logic [2:0]             rnd_mode_i,
  output fcvt_pkg::operand_u     result_o,
  output logic [4:0]             status_o
);

  localparam int W = `FCVT_WIDTH;

  logic               is_f2i, is_i2f, is_f16;
  logic               inexact, round_up;
  logic [W:0]         sum;  // Carry for unsigned overflow
  logic               exp_ones_after, exp_zero_after, of_any;
  logic               fp_spec, int_spec, int_of_post, neg_uns;
  logic               spec_ones, spec_sign;
  fcvt_pkg::operand_u fp_res, fp_spec_res, res_d;
  logic [W-1:0]       int_res, int_spec_res;
  logic [4:0]         status_d;

  assign is_f2i  = (op_i == `FCVT_OP_F2I);
  assign is_i2f  = (op_i == `FCVT_OP_I2F);
  assign is_f16  = (dst_fmt_i == `FCVT_FMT_F16);
  assign inexact = |rs_bits_i;

  // ----------------------------------------------------------
  // Rounding on the magnitude
  // ----------------------------------------------------------
  always_comb begin
    case (rnd_mode_i)
      `FCVT_RNE: round_up = rs_bits_i[1] & (rs_bits_i[0] | abs_i[0]);  // Ties to even
      `FCVT_RDN: round_up = inexact & sign_i;
      `FCVT_RUP: round_up = inexact & ~sign_i;
      `FCVT_RMM: round_up = rs_bits_i[1];
      default:   round_up = 1'b0;  // RTZ
    endcase
  end

  assign sum = {1'b0, abs_i} + {{W{1'b0}}, round_up};

  // ----------------------------------------------------------
  // Float destination
  // ----------------------------------------------------------
  assign spec_ones = is_nan_i | is_inf_i;
  assign spec_sign = sign_i & ~is_nan_i;  // Canonical NaN is positive
  // Integer zero gives +0 as its sign is clear
  assign fp_spec   = is_i2f ? mant_zero_i : (is_zero_i | spec_ones);

  always_comb begin
    fp_res.raw      = '1;  // NaN-box for binary16
    fp_spec_res.raw = '1;
    if (is_f16) begin
      fp_res.f16.sign               = sign_i;
      {fp_res.f16.exp, fp_res.f16.man} = sum[`FCVT_F16_EXP+`FCVT_F16_MAN-1:0];
      exp_ones_after                = &fp_res.f16.exp;
      exp_zero_after                = (fp_res.f16.exp == '0);
      fp_spec_res.f16.sign          = spec_sign;
      fp_spec_res.f16.exp           = {`FCVT_F16_EXP{spec_ones}};
      fp_spec_res.f16.man           = {is_nan_i, {(`FCVT_F16_MAN-1){1'b0}}};
    end else begin
      fp_res.f32.sign               = sign_i;
      {fp_res.f32.exp, fp_res.f32.man} = sum[W-2:0];
      exp_ones_after                = &fp_res.f32.exp;
      exp_zero_after                = (fp_res.f32.exp == '0);
      fp_spec_res.f32.sign          = spec_sign;
      fp_spec_res.f32.exp           = {`FCVT_F32_EXP{spec_ones}};
      fp_spec_res.f32.man           = {is_nan_i, {(`FCVT_F32_MAN-1){1'b0}}};
    end
  end

  assign of_any = of_pre_i | exp_ones_after;  // Rounded into the infinity exponent

  // ----------------------------------------------------------
  // Integer destination
  // ----------------------------------------------------------
  // Unsigned overflows on carry out, signed above 2^31-1 or below -2^31
  assign int_of_post = op_mod_i ? sum[W] : (sum[W-1] & (~sign_i | |sum[W-2:0]));
  assign neg_uns     = op_mod_i & sign_i & (sum[W-1:0] != '0);  // -0 is fine
  assign int_spec    = is_nan_i | is_inf_i | of_pre_i | int_of_post | neg_uns;
  assign int_res     = sign_i ? -sum[W-1:0] : sum[W-1:0];

  // Saturate with NaN to the positive maximum
  always_comb begin
    if (is_nan_i || !sign_i) int_spec_res = {op_mod_i, {(W-1){1'b1}}};
    else                     int_spec_res = {~op_mod_i, {(W-1){1'b0}}};
  end

  // ----------------------------------------------------------
  // Result and status selection
  // ----------------------------------------------------------
  always_comb begin
    status_d = '0;  // DZ stays clear
    if (is_f2i) begin
      res_d.raw = int_spec ? int_spec_res : int_res;
      if (int_spec) status_d[`FCVT_NV] = 1'b1;
      else          status_d[`FCVT_NX] = inexact;
    end else if (fp_spec) begin
      res_d              = fp_spec_res;
      status_d[`FCVT_NV] = is_snan_i & ~is_i2f;
    end else begin
      res_d              = fp_res;
      status_d[`FCVT_OF] = of_any;
      status_d[`FCVT_UF] = uf_pre_i & exp_zero_after & inexact;  // Tiny after rounding
      status_d[`FCVT_NX] = inexact | of_any;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i)  status_o <= '0;
    else if (en_i) status_o <= status_d;
  end

  always_ff @(posedge clk_i) begin
    if (en_i) result_o <= res_d;
  end

endmodule

/* verilog/fcvt_stage_ctrl.sv */
// ----------------------------------------------------------
// Valid/ready control of the two pipeline stages
// Drives the stage load enables and the external handshake
// ----------------------------------------------------------
`timescale 1ns/1ps

module fcvt_stage_ctrl (
  input  logic clk_i,
  input  logic rst_n_i,
  input  logic in_valid_i,
  input  logic out_ready_i,
  output logic in_ready_o,
  output logic s1_en_o,
  output logic s2_en_o,
  output logic out_valid_o,
  output logic busy_o
);

  logic s1_valid;  // Stage 1 holds a conversion
  logic s2_valid;  // Stage 2 holds a conversion

  // Stage loads when empty or when its contents move on
  assign s2_en_o = ~s2_valid | out_ready_i;
  assign s1_en_o = ~s1_valid | s2_en_o;

  assign in_ready_o  = s1_en_o;
  assign out_valid_o = s2_valid;
  assign busy_o      = s1_valid | s2_valid;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      s1_valid <= 1'b0;
      s2_valid <= 1'b0;
    end else begin
      if (s1_en_o) s1_valid <= in_valid_i;  // Bubble when no input
      if (s2_en_o) s2_valid <= s1_valid;
    end
  end

endmodule

/* verilog/fcvt_top.sv */
// ----------------------------------------------------------
// Conversion unit top: stage controller, unpack stage,
// alignment and round stage, two cycles of latency
// ----------------------------------------------------------
`timescale 1ns/1ps
`include "fcvt_cfg.svh"

module fcvt_top (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  logic               in_valid_i,
  input  logic               out_ready_i,
  input  logic               op_mod_i,
  input  logic               src_fmt_i,
  input  logic               dst_fmt_i,
  input  fcvt_pkg::operand_u operand_i,
  input  logic [1:0]         op_i,
  input  logic [2:0]         rnd_mode_i,
  output logic               in_ready_o,
  output logic               out_valid_o,
  output logic               busy_o,
  output fcvt_pkg::operand_u result_o,
  output logic [4:0]         status_o
);

  logic                          s1_en, s2_en;
  // Stage 1 outputs
  logic                          u_sign, u_is_zero, u_is_inf, u_is_nan, u_is_snan, u_mant_zero;
  logic signed [`FCVT_EXP_W-1:0] u_exp;
  logic [`FCVT_MAN_W-1:0]        u_mant;
  logic [1:0]                    u_op;
  logic                          u_op_mod, u_dst_fmt;
  logic [2:0]                    u_rnd_mode;
  // Alignment outputs
  logic [`FCVT_WIDTH-1:0]        a_abs;
  logic [1:0]                    a_rs_bits;
  logic                          a_of_pre, a_uf_pre;

  fcvt_stage_ctrl i_stage_ctrl (
    .clk_i       (clk_i),       .rst_n_i     (rst_n_i),
    .in_valid_i  (in_valid_i),  .out_ready_i (out_ready_i),
    .in_ready_o  (in_ready_o),  .s1_en_o     (s1_en),
    .s2_en_o     (s2_en),       .out_valid_o (out_valid_o),
    .busy_o      (busy_o)
  );

  fcvt_unpack i_unpack (
    .clk_i       (clk_i),       .rst_n_i     (rst_n_i),     .en_i      (s1_en),
    .operand_i   (operand_i),   .op_i        (op_i),        .op_mod_i  (op_mod_i),
    .src_fmt_i   (src_fmt_i),   .dst_fmt_i   (dst_fmt_i),   .rnd_mode_i (rnd_mode_i),
    .sign_o      (u_sign),      .is_zero_o   (u_is_zero),   .is_inf_o  (u_is_inf),
    .is_nan_o    (u_is_nan),    .is_snan_o   (u_is_snan),   .mant_zero_o (u_mant_zero),
    .exp_o       (u_exp),       .mant_o      (u_mant),      .op_o      (u_op),
    .op_mod_o    (u_op_mod),    .dst_fmt_o   (u_dst_fmt),   .rnd_mode_o (u_rnd_mode)
  );

  fcvt_align i_align (
    .exp_i       (u_exp),       .mant_i      (u_mant),      .op_i      (u_op),
    .op_mod_i    (u_op_mod),    .dst_fmt_i   (u_dst_fmt),   .is_inf_i  (u_is_inf),
    .abs_o       (a_abs),       .rs_bits_o   (a_rs_bits),
    .of_pre_o    (a_of_pre),    .uf_pre_o    (a_uf_pre)
  );

  fcvt_round i_round (
    .clk_i       (clk_i),       .rst_n_i     (rst_n_i),     .en_i      (s2_en),
    .abs_i       (a_abs),       .rs_bits_i   (a_rs_bits),   .sign_i    (u_sign),
    .of_pre_i    (a_of_pre),    .uf_pre_i    (a_uf_pre),    .is_zero_i (u_is_zero),
    .is_inf_i    (u_is_inf),    .is_nan_i    (u_is_nan),    .is_snan_i (u_is_snan),
    .mant_zero_i (u_mant_zero), .op_i        (u_op),        .op_mod_i  (u_op_mod),
    .dst_fmt_i   (u_dst_fmt),   .rnd_mode_i  (u_rnd_mode),
    .result_o    (result_o),    .status_o    (status_o)
  );

endmodule

/* verilog/fcvt_unpack.sv */
// ----------------------------------------------------------
// First stage: classify the source, take the integer magnitude,
// normalize the mantissa and register the result on en_i
// ----------------------------------------------------------
`timescale 1ns/1ps
`include "fcvt_cfg.svh"

module fcvt_unpack (
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  input  logic                          en_i,
  input  fcvt_pkg::operand_u            operand_i,
  input  logic [1:0]                    op_i,
  input  logic                          op_mod_i,
  input  logic                          src_fmt_i,
  input  logic                          dst_fmt_i,
  input  logic [2:0]                    rnd_mode_i,
  output logic                          sign_o,
  output logic                          is_zero_o,
  output logic                          is_inf_o,
  output logic                          is_nan_o,
  output logic                          is_snan_o,
  output logic                          mant_zero_o,
  output logic signed [`FCVT_EXP_W-1:0] exp_o,
  output logic [`FCVT_MAN_W-1:0]        mant_o,
  output logic [1:0]                    op_o,
  output logic                          op_mod_o,
  output logic                          dst_fmt_o,
  output logic [2:0]                    rnd_mode_o
);

  localparam int EW = `FCVT_EXP_W;
  localparam int MW = `FCVT_MAN_W;

  logic                   is_i2f;
  logic                   f_sign, exp_zero, exp_ones, man_zero, man_msb;
  logic signed [EW-1:0]   exp_biased, src_bias, fp_exp, int_exp;
  logic [MW-1:0]          fp_mant, int_mag, enc_mant;
  logic                   int_sign;
  logic [`FCVT_LZC_W-1:0] lzc;

  assign is_i2f = (op_i == `FCVT_OP_I2F);

  // ----------------------------------------------------------
  // Float decode through the union
  // ----------------------------------------------------------
  always_comb begin
    if (src_fmt_i == `FCVT_FMT_F16) begin
      f_sign     = operand_i.f16.sign;
      exp_zero   = (operand_i.f16.exp == '0);
      exp_ones   = &operand_i.f16.exp;
      man_zero   = (operand_i.f16.man == '0);
      man_msb    = operand_i.f16.man[`FCVT_F16_MAN-1];  // Quiet bit
      exp_biased = EW'(operand_i.f16.exp);
      src_bias   = EW'(`FCVT_F16_BIAS);
      // Implicit bit lands on the MSB
      fp_mant    = {~exp_zero, operand_i.f16.man, {(MW-1-`FCVT_F16_MAN){1'b0}}};
    end else begin
      f_sign     = operand_i.f32.sign;
      exp_zero   = (operand_i.f32.exp == '0);
      exp_ones   = &operand_i.f32.exp;
      man_zero   = (operand_i.f32.man == '0);
      man_msb    = operand_i.f32.man[`FCVT_F32_MAN-1];
      exp_biased = EW'(operand_i.f32.exp);
      src_bias   = EW'(`FCVT_F32_BIAS);
      fp_mant    = {~exp_zero, operand_i.f32.man, {(MW-1-`FCVT_F32_MAN){1'b0}}};
    end
  end

  // Integer source, signed only when op_mod is low
  assign int_sign = operand_i.raw[`FCVT_WIDTH-1] & ~op_mod_i;
  assign int_mag  = int_sign ? -operand_i.raw : operand_i.raw;
  assign enc_mant = is_i2f ? int_mag : fp_mant;

  // Leading-zero count, zero for an empty mantissa
  always_comb begin
    lzc = '0;
    for (int i = 0; i < MW; i++) begin
      if (enc_mant[i]) lzc = `FCVT_LZC_W'(MW - 1 - i);
    end
  end

  // Unbiased exponent, compensated for the normalizing shift
  assign fp_exp  = exp_biased + EW'(exp_zero) - src_bias - EW'(lzc);
  assign int_exp = EW'(MW - 1) - EW'(lzc);

  // ----------------------------------------------------------
  // Stage 1 register
  // ----------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      is_zero_o <= 1'b0;
      is_inf_o  <= 1'b0;
      is_nan_o  <= 1'b0;
      is_snan_o <= 1'b0;
    end else if (en_i) begin
      is_zero_o <= ~is_i2f & exp_zero & man_zero;
      is_inf_o  <= ~is_i2f & exp_ones & man_zero;
      is_nan_o  <= ~is_i2f & exp_ones & ~man_zero;
      is_snan_o <= ~is_i2f & exp_ones & ~man_zero & ~man_msb;
    end
  end

  always_ff @(posedge clk_i) begin
    if (en_i) begin
      sign_o      <= is_i2f ? int_sign : f_sign;
      mant_zero_o <= (enc_mant == '0);
      exp_o       <= is_i2f ? int_exp : fp_exp;
      mant_o      <= enc_mant << lzc;  // Normalized, MSB set
      op_o        <= op_i;
      op_mod_o    <= op_mod_i;
      dst_fmt_o   <= dst_fmt_i;
      rnd_mode_o  <= rnd_mode_i;
    end
  end

endmodule
